// File: design/sgb_pkg.sv
package sgb_pkg;

	// ==================================================
	// Widths with a meaning
	// ==================================================
	typedef logic [24:0] io_addr_t;
	typedef logic [15:0] io_word_t;
	typedef logic [7:0] io_index_t;
	typedef logic signed [15:0] sample_t;
	typedef logic [7:0] ram_data_t;

	// Download index values, compared on the low six bits
	localparam logic [5:0] IDX_GB_CART = 6'd1;
	localparam logic [5:0] IDX_MSU_DATA = 6'd3;
	localparam logic [5:0] IDX_SNES_CART = 6'd4;
	localparam logic [5:0] IDX_SGB_BOOT = 6'd5;

	// ==================================================
	// Bundles
	// ==================================================
	// One beat of the host download stream
	typedef struct packed {
		logic wr;
		io_addr_t addr;
		io_word_t data;
	} io_write_t;

	// Level flags, one per download kind
	typedef struct packed {
		logic code;
		logic snes_cart;
		logic gb_cart;
		logic sgb_boot;
		logic msu_data;
	} load_kind_t;

	// Cheat record, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef enum logic [0:0] {CLR_IDLE, CLR_SWEEP} clear_state_t;

endpackage

// File: design/load_decode.sv
module load_decode (
	input logic clk_sys,
	input logic RESET,
	input logic io_download,
	input sgb_pkg::io_index_t io_index,
	output sgb_pkg::load_kind_t kind,
	output logic loading,
	output logic cart_start
);

	logic snes_prev;

	// Index decode, only while the host is sending
	always_comb begin
		kind.code = io_download & (&io_index);
		kind.snes_cart = io_download & (io_index[5:0] == sgb_pkg::IDX_SNES_CART);
		kind.gb_cart = io_download &
			((io_index[5:0] == sgb_pkg::IDX_GB_CART) | (io_index == '0));
		kind.sgb_boot = io_download & (io_index[5:0] == sgb_pkg::IDX_SGB_BOOT);
		kind.msu_data = io_download & (io_index[5:0] == sgb_pkg::IDX_MSU_DATA);
	end

	// Downloads that hold the console in reset
	assign loading = kind.snes_cart | kind.gb_cart | kind.sgb_boot;

	// Rising edge of the SNES cart flag
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			snes_prev <= 1'b0;
			cart_start <= 1'b0;
		end else begin
			snes_prev <= kind.snes_cart;
			cart_start <= kind.snes_cart & ~snes_prev;
		end
	end

	// Start pulse is a single cycle even for a long download
	a_cart_start_pulse: assert property (
		@(posedge clk_sys) disable iff (RESET)
		cart_start |=> !cart_start
	) else $error("cart_start held for two cycles");

endmodule

// File: design/cheat_code_assembler.sv
module cheat_code_assembler (
	input logic clk_sys,
	input logic RESET,
	input logic code_load,
	input sgb_pkg::io_write_t io_wr,
	output sgb_pkg::cheat_code_t cheat,
	output logic cheat_valid
);

	logic code_wr;

	assign code_wr = code_load & io_wr.wr;

	// ==================================================
	// Record assembly
	// ==================================================
	// Low word at the even offset, high word two bytes above
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (io_wr.addr[3:0])
				4'd0: cheat.flags[15:0] <= io_wr.data;
				4'd2: cheat.flags[31:16] <= io_wr.data;
				4'd4: cheat.address[15:0] <= io_wr.data;
				4'd6: cheat.address[31:16] <= io_wr.data;
				4'd8: cheat.compare[15:0] <= io_wr.data;
				4'd10: cheat.compare[31:16] <= io_wr.data;
				4'd12: cheat.replace[15:0] <= io_wr.data;
				4'd14: cheat.replace[31:16] <= io_wr.data;
				default: ;
			endcase
		end
	end

	// Last word of the record clocks it out
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr & (io_wr.addr[3:0] == 4'd14);
		end
	end

	// Strobe is a single cycle per record
	a_cheat_valid_pulse: assert property (
		@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid
	) else $error("cheat_valid high two cycles in a row");

endmodule

// File: design/ram_clear_engine.sv
module ram_clear_engine #(
	parameter int CLEAR_ADDR_W = 17
) (
	input logic clk_sys,
	input logic RESET,
	input logic cart_start,
	input logic loading,
	output logic [CLEAR_ADDR_W-1:0] fill_addr,
	output sgb_pkg::ram_data_t fill_data,
	output logic clearing,
	output logic emu_reset
);

	sgb_pkg::clear_state_t state;

	// ==================================================
	// Sweep FSM
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state <= sgb_pkg::CLR_IDLE;
			fill_addr <= '0;
		end else begin
			case (state)
				sgb_pkg::CLR_IDLE: begin
					fill_addr <= '0;
					if (cart_start) begin
						state <= sgb_pkg::CLR_SWEEP;
					end
				end
				sgb_pkg::CLR_SWEEP: begin
					fill_addr <= fill_addr + 1'b1;
					// Top address written, back to idle
					if (&fill_addr) begin
						state <= sgb_pkg::CLR_IDLE;
					end
				end
				default: state <= sgb_pkg::CLR_IDLE;
			endcase
		end
	end

	assign clearing = (state == sgb_pkg::CLR_SWEEP);

	// Alternating 0x66/0x99 work RAM power-on pattern
	assign fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;

	// Console held in reset through loads and the sweep
	always_ff @(posedge clk_sys) begin
		emu_reset <= RESET | loading | clearing;
	end

	a_fill_addr_step: assert property (
		@(posedge clk_sys) disable iff (RESET)
		clearing && $past(clearing) |->
			fill_addr == CLEAR_ADDR_W'($past(fill_addr) + 1'b1)
	) else $error("fill_addr skipped during sweep");

endmodule

// File: design/audio_mixer.sv
module audio_mixer (
	input logic clk_sys,
	input logic RESET,
	input sgb_pkg::stereo_t snes_audio,
	input sgb_pkg::stereo_t gb_audio,
	input sgb_pkg::stereo_t msu_audio,
	input logic msu_enable,
	input logic audio_mute,
	output sgb_pkg::stereo_t audio_out
);

	// One channel of the mix
	function automatic sgb_pkg::sample_t mix_channel(
		input sgb_pkg::sample_t snes,
		input sgb_pkg::sample_t gb,
		input sgb_pkg::sample_t msu,
		input logic msu_en
	);
		logic [15:0] gb_wide;
		logic [16:0] base_sum;
		logic [16:0] msu_sum;
		// GB output is quieter, scale up by four and keep the sign
		gb_wide = {gb[15], gb[12:0], 2'b00};
		base_sum = {snes[15], snes} + {gb_wide[15], gb_wide};
		msu_sum = {base_sum[16], base_sum[16:1]} + {msu[15], msu};
		return msu_en ? msu_sum[16:1] : base_sum[16:1];
	endfunction

	// ==================================================
	// Output register
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			audio_out <= '0;
		end else if (audio_mute) begin
			audio_out <= '0;
		end else begin
			audio_out.left <= mix_channel(snes_audio.left, gb_audio.left,
				msu_audio.left, msu_enable);
			audio_out.right <= mix_channel(snes_audio.right, gb_audio.right,
				msu_audio.right, msu_enable);
		end
	end

	a_mute_silent: assert property (
		@(posedge clk_sys) disable iff (RESET)
		audio_mute |=> audio_out == '0
	) else $error("audio_out not silent after mute");

endmodule

// File: design/sgb_loader_top.sv
module sgb_loader_top #(
	parameter int CLEAR_ADDR_W = 17
) (
	input logic clk_sys,
	input logic RESET,

	// Host download stream
	input logic io_download,
	input sgb_pkg::io_index_t io_index,
	input sgb_pkg::io_write_t io_wr,

	// Audio sources
	input sgb_pkg::stereo_t snes_audio,
	input sgb_pkg::stereo_t gb_audio,
	input sgb_pkg::stereo_t msu_audio,
	input logic msu_enable,
	input logic audio_mute,

	output sgb_pkg::cheat_code_t cheat,
	output logic cheat_valid,
	output logic [CLEAR_ADDR_W-1:0] fill_addr,
	output sgb_pkg::ram_data_t fill_data,
	output logic clearing,
	output logic emu_reset,
	output sgb_pkg::stereo_t audio_out
);

	sgb_pkg::load_kind_t kind;
	logic loading;
	logic cart_start;

	load_decode load_decode_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.io_download(io_download),
		.io_index(io_index),
		.kind(kind),
		.loading(loading),
		.cart_start(cart_start)
	);

	cheat_code_assembler cheat_code_assembler_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.code_load(kind.code),
		.io_wr(io_wr),
		.cheat(cheat),
		.cheat_valid(cheat_valid)
	);

	ram_clear_engine #(.CLEAR_ADDR_W(CLEAR_ADDR_W)) ram_clear_engine_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.cart_start(cart_start),
		.loading(loading),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.clearing(clearing),
		.emu_reset(emu_reset)
	);

	audio_mixer audio_mixer_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.snes_audio(snes_audio),
		.gb_audio(gb_audio),
		.msu_audio(msu_audio),
		.msu_enable(msu_enable),
		.audio_mute(audio_mute),
		.audio_out(audio_out)
	);

endmodule

// File: dv/sgb_loader_tests.svh
// ==================================================
// Reference models
// ==================================================
// 0x66 where address bits 8 and 2 differ
function automatic sgb_pkg::ram_data_t expected_fill(input logic [CLR_W-1:0] addr);
	if (addr[8] != addr[2]) begin
		return 8'h66;
	end
	return 8'h99;
endfunction

function automatic sgb_pkg::sample_t expected_mix(input sgb_pkg::sample_t snes,
	input sgb_pkg::sample_t gb, input sgb_pkg::sample_t msu, input logic msu_on,
	input logic mute);
	logic signed [15:0] gb_wide;
	int mix;
	if (mute) begin
		return '0;
	end
	gb_wide = {gb[15], gb[12:0], 2'b00};
	mix = (int'(snes) + int'(gb_wide)) >>> 1;
	if (msu_on) begin
		mix = (mix + int'(msu)) >>> 1;
	end
	return sgb_pkg::sample_t'(mix);
endfunction

// ==================================================
// Directed tests
// ==================================================
task automatic test_cheat_record();
	sgb_pkg::io_word_t words [8];
	io_download = 1'b1;
	io_index = 8'hff;
	for (int i = 0; i < 8; i++) begin
		words[i] = sgb_pkg::io_word_t'($urandom);
		io_wr.wr = 1'b1;
		io_wr.addr = sgb_pkg::io_addr_t'(2 * i);
		io_wr.data = words[i];
		next_cycle();
		// Strobe only after the word at offset 14
		check_bit("cheat_valid", cheat_valid, i == 7);
	end
	exp_cheat.flags = {words[1], words[0]};
	exp_cheat.address = {words[3], words[2]};
	exp_cheat.compare = {words[5], words[4]};
	exp_cheat.replace = {words[7], words[6]};
	check_cheat("cheat", cheat, exp_cheat);
	io_wr.wr = 1'b0;
	next_cycle();
	check_bit("cheat_valid", cheat_valid, 1'b0);
endtask

task automatic test_offsets_index();
	// Odd offsets under the cheat index
	for (int i = 0; i < 8; i++) begin
		io_wr.wr = 1'b1;
		io_wr.addr = sgb_pkg::io_addr_t'($urandom);
		io_wr.addr[3:0] = 4'(2 * i + 1);
		io_wr.data = sgb_pkg::io_word_t'($urandom);
		next_cycle();
		check_bit("cheat_valid", cheat_valid, 1'b0);
	end
	// Even offsets under an index that is not all ones
	io_index = 8'h7f;
	for (int i = 0; i < 8; i++) begin
		io_wr.addr = sgb_pkg::io_addr_t'(2 * i);
		io_wr.data = sgb_pkg::io_word_t'($urandom);
		next_cycle();
		check_bit("cheat_valid", cheat_valid, 1'b0);
	end
	// Cheat index with no download active
	io_index = 8'hff;
	io_download = 1'b0;
	next_cycle();
	check_bit("cheat_valid", cheat_valid, 1'b0);
	io_wr.wr = 1'b0;
	io_index = '0;
	next_cycle();
	check_bit("cheat_valid", cheat_valid, 1'b0);
	check_cheat("cheat", cheat, exp_cheat);
endtask

task automatic test_clear_sweep();
	logic [CLR_W-1:0] exp_addr;
	io_download = 1'b1;
	io_index = 8'h04;
	next_cycle();
	check_bit("clearing", clearing, 1'b0);
	next_cycle();
	for (int a = 0; a < 2 ** CLR_W; a++) begin
		exp_addr = CLR_W'(a);
		check_bit("clearing", clearing, 1'b1);
		check_addr("fill_addr", fill_addr, exp_addr);
		check_byte("fill_data", fill_data, expected_fill(exp_addr));
		check_bit("emu_reset", emu_reset, 1'b1);
		// Short download, then a second start inside the sweep
		if (a == 8 || a == 16) begin
			io_download = 1'b0;
		end
		if (a == 12) begin
			io_download = 1'b1;
		end
		next_cycle();
	end
	check_bit("clearing", clearing, 1'b0);
	check_bit("emu_reset", emu_reset, 1'b1);
	next_cycle();
	check_bit("clearing", clearing, 1'b0);
	check_bit("emu_reset", emu_reset, 1'b0);
	io_index = '0;
endtask

task automatic test_emu_reset();
	io_download = 1'b1;
	io_index = 8'h01;
	for (int i = 0; i < 8; i++) begin
		next_cycle();
		check_bit("emu_reset", emu_reset, 1'b1);
		check_bit("clearing", clearing, 1'b0);
	end
	io_download = 1'b0;
	next_cycle();
	check_bit("emu_reset", emu_reset, 1'b0);
	// All zero index loads a Game Boy cart too
	io_download = 1'b1;
	io_index = 8'h00;
	next_cycle();
	check_bit("emu_reset", emu_reset, 1'b1);
	io_download = 1'b0;
	next_cycle();
	check_bit("emu_reset", emu_reset, 1'b0);
	check_bit("clearing", clearing, 1'b0);
endtask

task automatic test_audio_mix();
	sgb_pkg::stereo_t exp;
	for (int i = 0; i < 48; i++) begin
		snes_audio = sgb_pkg::stereo_t'($urandom);
		gb_audio = sgb_pkg::stereo_t'($urandom);
		msu_audio = sgb_pkg::stereo_t'($urandom);
		msu_enable = (i >= 16);
		audio_mute = (i >= 32) ? ($urandom_range(1) == 1) : 1'b0;
		exp.left = expected_mix(snes_audio.left, gb_audio.left, msu_audio.left,
			msu_enable, audio_mute);
		exp.right = expected_mix(snes_audio.right, gb_audio.right, msu_audio.right,
			msu_enable, audio_mute);
		next_cycle();
		check_stereo("audio_out", audio_out, exp);
	end
	msu_enable = 1'b0;
	audio_mute = 1'b0;
endtask

// File: dv/sgb_loader_tb.sv
module sgb_loader_tb;

	localparam int CLR_W = 10;
	localparam int CLK_PERIOD = 8;
	// Reset, cheat, offsets, sweep, emu reset, audio
	localparam int TEST_CYCLES = 10 + 12 + 24 + 1040 + 24 + 52;
	localparam int WATCHDOG_TIME = 4 * TEST_CYCLES * CLK_PERIOD;

	logic clk_sys;
	logic RESET;
	logic io_download;
	sgb_pkg::io_index_t io_index;
	sgb_pkg::io_write_t io_wr;
	sgb_pkg::stereo_t snes_audio;
	sgb_pkg::stereo_t gb_audio;
	sgb_pkg::stereo_t msu_audio;
	logic msu_enable;
	logic audio_mute;
	sgb_pkg::cheat_code_t cheat;
	logic cheat_valid;
	logic [CLR_W-1:0] fill_addr;
	sgb_pkg::ram_data_t fill_data;
	logic clearing;
	logic emu_reset;
	sgb_pkg::stereo_t audio_out;

	int checks;
	int errors;
	// Record last loaded by the cheat test
	sgb_pkg::cheat_code_t exp_cheat;

	sgb_loader_top #(.CLEAR_ADDR_W(CLR_W)) sgb_loader_top_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.io_download(io_download),
		.io_index(io_index),
		.io_wr(io_wr),
		.snes_audio(snes_audio),
		.gb_audio(gb_audio),
		.msu_audio(msu_audio),
		.msu_enable(msu_enable),
		.audio_mute(audio_mute),
		.cheat(cheat),
		.cheat_valid(cheat_valid),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.clearing(clearing),
		.emu_reset(emu_reset),
		.audio_out(audio_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_sys = ~clk_sys;
		end
	end

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_cheat(input string name, input sgb_pkg::cheat_code_t got,
		input sgb_pkg::cheat_code_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_stereo(input string name, input sgb_pkg::stereo_t got,
		input sgb_pkg::stereo_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input sgb_pkg::ram_data_t got,
		input sgb_pkg::ram_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [CLR_W-1:0] got,
		input logic [CLR_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Outputs settle at the edge, inputs change 1 unit later
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	`include "sgb_loader_tests.svh"

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired after %0d time units, tests did not finish", WATCHDOG_TIME);
		$display("Test failed");
		$finish;
	end

	initial begin
		int seed;
		seed = 32'h45aeffbb;
		void'($urandom(seed));
		checks = 0;
		errors = 0;
		RESET = 1'b1;
		io_download = 1'b0;
		io_index = '0;
		io_wr = '0;
		snes_audio = '0;
		gb_audio = '0;
		msu_audio = '0;
		msu_enable = 1'b0;
		audio_mute = 1'b0;
		repeat (10) @(posedge clk_sys);
		#1;
		// State held by reset
		check_bit("cheat_valid", cheat_valid, 1'b0);
		check_bit("clearing", clearing, 1'b0);
		check_bit("emu_reset", emu_reset, 1'b1);
		check_stereo("audio_out", audio_out, '0);
		RESET = 1'b0;
		test_cheat_record();
		test_offsets_index();
		test_clear_sweep();
		test_emu_reset();
		test_audio_mix();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+dv
design/sgb_pkg.sv
design/load_decode.sv
design/cheat_code_assembler.sv
design/ram_clear_engine.sv
design/audio_mixer.sv
design/sgb_loader_top.sv
dv/sgb_loader_tb.sv
